// ==== filelist.f ====
+incdir+hdl
hdl/fpga_bridge_pkg.sv
hdl/reg_wr_if.sv
hdl/lint_slave.sv
hdl/tcdm_port.sv
hdl/gpio_regs.sv
hdl/read_mux.sv
hdl/fpga_bridge_top.sv
bench/tb_fpga_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fpga bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_fpga_bridge -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation finished cleanly"

// ==== bench/tb_fpga_bridge.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

module tb_fpga_bridge;

   logic                                CLK;
   logic                                rst;
   logic                                lint_req;
   logic                                lint_wen;
   fpga_bridge_pkg::bus_addr_t          lint_addr;
   fpga_bridge_pkg::word_t              lint_wdata;
   fpga_bridge_pkg::be_t                lint_be;
   wire                                 lint_gnt;
   wire                                 lint_valid;
   wire fpga_bridge_pkg::word_t         lint_rdata;
   wire fpga_bridge_pkg::gpio_t         fpgaio_out;
   wire fpga_bridge_pkg::gpio_t         fpgaio_oe;
   fpga_bridge_pkg::gpio_t              fpgaio_in;
   wire fpga_bridge_pkg::tcdm_addr_t    tcdm_addr [`FB_NUM_PORTS];
   wire [`FB_NUM_PORTS-1:0]             tcdm_we;
   wire fpga_bridge_pkg::be_t           tcdm_be [`FB_NUM_PORTS];
   wire fpga_bridge_pkg::word_t         tcdm_wdata [`FB_NUM_PORTS];
   wire [`FB_NUM_PORTS-1:0]             tcdm_req;
   wire [`FB_NUM_PORTS-1:0]             tcdm_gnt;
   wire [`FB_NUM_PORTS-1:0]             tcdm_valid;
   wire fpga_bridge_pkg::word_t         tcdm_rdata [`FB_NUM_PORTS];

   // reference model, written only by the stimulus process
   int                                  seed;
   int                                  n_trans;
   int                                  cycle_cnt;
   logic                                chk_rd;
   fpga_bridge_pkg::word_t              exp_rd;
   fpga_bridge_pkg::bus_addr_t          chk_addr;
   fpga_bridge_pkg::gpio_t              exp_out;
   fpga_bridge_pkg::gpio_t              exp_oe;
   fpga_bridge_pkg::gpio_t              nxt_out;   // applied when the write is granted
   fpga_bridge_pkg::gpio_t              nxt_oe;
   fpga_bridge_pkg::word_t              exp_cmd [`FB_NUM_PORTS];
   fpga_bridge_pkg::be_t                exp_be [`FB_NUM_PORTS];
   fpga_bridge_pkg::word_t              exp_wd [`FB_NUM_PORTS];
   logic [`FB_NUM_PORTS-1:0]            launched;
   logic [`FB_NUM_PORTS-1:0]            resp_en;   // responder may grant
   int                                  resp_delay [`FB_NUM_PORTS];
   fpga_bridge_pkg::word_t              resp_word [`FB_NUM_PORTS];

   fpga_bridge_top UUT (.*);

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   function automatic fpga_bridge_pkg::bus_addr_t reg_addr(
      input fpga_bridge_pkg::bus_addr_t base,
      input int                         idx
   );
      return base + fpga_bridge_pkg::bus_addr_t'(4 * idx);
   endfunction

   // word k of an 80 bit register as seen on the bus
   function automatic fpga_bridge_pkg::word_t expected_slice(
      input fpga_bridge_pkg::gpio_t v,
      input int                     k
   );
      if (k == 2) begin
         return {16'h0000, v[`FB_GPIO_W-1:64]};
      end
      return v[k*32 +: 32];
   endfunction

   task automatic next_cycle();
      @(posedge CLK);
      #5;
   endtask

   // one lint transfer, returns once valid has been sampled
   task automatic bus_access(
      input logic                       write,
      input fpga_bridge_pkg::bus_addr_t a,
      input fpga_bridge_pkg::word_t     d,
      input fpga_bridge_pkg::be_t       b
   );
      n_trans++;
      lint_req   = 1'b1;
      lint_wen   = !write;
      lint_addr  = a;
      lint_wdata = d;
      lint_be    = b;
      do next_cycle(); while (!lint_gnt);
      lint_req = 1'b0;
      exp_out  = nxt_out;  // gpio write takes effect on the gnt edge
      exp_oe   = nxt_oe;
      do next_cycle(); while (!lint_valid);
      next_cycle();
   endtask

   task automatic bus_read(
      input fpga_bridge_pkg::bus_addr_t a,
      input fpga_bridge_pkg::word_t     expected
   );
      exp_rd   = expected;
      chk_addr = a;
      chk_rd   = 1'b1;
      bus_access(1'b0, a, '0, '0);
      chk_rd   = 1'b0;
   endtask

   a_reset_state: assert property (@(posedge CLK)
      $fell(rst) |-> !lint_gnt && !lint_valid && tcdm_req == '0 && lint_rdata == '0
   ) else report_failure($sformatf(
      "** Error: after reset gnt=0x%h valid=0x%h tcdm_req=0x%h rdata=0x%h",
      lint_gnt, lint_valid, tcdm_req, lint_rdata));

   a_gnt_timing: assert property (@(posedge CLK) disable iff (rst)
      $rose(lint_req) |=> !lint_gnt ##1 (lint_gnt && !lint_valid)
   ) else report_failure($sformatf("** Error: lint_gnt = 0x%h one cycle after req, expected 0x1",
                                   lint_gnt));

   a_valid_timing: assert property (@(posedge CLK) disable iff (rst)
      lint_gnt |=> !lint_gnt && lint_valid
   ) else report_failure($sformatf("** Error: lint_valid = 0x%h after gnt, expected 0x1",
                                   lint_valid));

   a_valid_pulse: assert property (@(posedge CLK) disable iff (rst)
      lint_valid |=> !lint_valid
   ) else report_failure("lint_valid stayed high for more than one cycle");

   a_read_data: assert property (@(posedge CLK) disable iff (rst)
      lint_valid && chk_rd |-> lint_rdata == exp_rd
   ) else report_failure($sformatf("** Error: lint_rdata = 0x%h, expected 0x%h at addr 0x%h",
                                   lint_rdata, exp_rd, chk_addr));

   a_gpio_out: assert property (@(posedge CLK) disable iff (rst) fpgaio_out == exp_out)
      else report_failure($sformatf("** Error: fpgaio_out = 0x%h, expected 0x%h",
                                    fpgaio_out, exp_out));

   a_gpio_oe: assert property (@(posedge CLK) disable iff (rst) fpgaio_oe == exp_oe)
      else report_failure($sformatf("** Error: fpgaio_oe = 0x%h, expected 0x%h",
                                    fpgaio_oe, exp_oe));

   for (genvar g = 0; g < `FB_NUM_PORTS; g++) begin : g_port
      logic                   gnt_q;
      logic                   valid_q;
      fpga_bridge_pkg::word_t rdata_q;

      assign tcdm_gnt[g]   = gnt_q;
      assign tcdm_valid[g] = valid_q;
      assign tcdm_rdata[g] = rdata_q;

      // responder: grant after resp_delay, valid two cycles after the grant
      initial begin
         gnt_q   = 1'b0;
         valid_q = 1'b0;
         rdata_q = '0;
         forever begin
            next_cycle();
            if (tcdm_req[g] && resp_en[g]) begin
               repeat (resp_delay[g]) next_cycle();
               gnt_q = 1'b1;
               next_cycle();
               gnt_q = 1'b0;
               next_cycle();
               valid_q = 1'b1;
               rdata_q = resp_word[g];
               next_cycle();
               valid_q = 1'b0;
            end
         end
      end

      a_req_launch: assert property (@(posedge CLK) disable iff (rst)
         $rose(tcdm_req[g]) |-> launched[g]
      ) else report_failure($sformatf("tcdm_req of port %0d rose without a request strobe", g));

      a_req_hold: assert property (@(posedge CLK) disable iff (rst)
         tcdm_req[g] && !tcdm_gnt[g] |=> tcdm_req[g]
      ) else report_failure($sformatf("tcdm_req of port %0d dropped before grant", g));

      a_req_drop: assert property (@(posedge CLK) disable iff (rst)
         tcdm_req[g] && tcdm_gnt[g] |=> !tcdm_req[g]
      ) else report_failure($sformatf("tcdm_req of port %0d still high after grant", g));

      a_req_addr: assert property (@(posedge CLK) disable iff (rst)
         tcdm_req[g] |-> tcdm_addr[g] == exp_cmd[g][`FB_TCDM_ADDR_W-1:0]
      ) else report_failure($sformatf("** Error: tcdm_addr[%0d] = 0x%h, expected 0x%h",
                                      g, tcdm_addr[g], exp_cmd[g][`FB_TCDM_ADDR_W-1:0]));

      a_req_fields: assert property (@(posedge CLK) disable iff (rst)
         tcdm_req[g] |-> tcdm_wdata[g] == exp_wd[g] && tcdm_be[g] == exp_be[g]
            && tcdm_we[g] == exp_cmd[g][`FB_CMD_WE_BIT]
      ) else report_failure($sformatf(
         "** Error: port %0d tcdm_wdata=0x%h be=0x%h we=0x%h, expected 0x%h 0x%h 0x%h",
         g, tcdm_wdata[g], tcdm_be[g], tcdm_we[g], exp_wd[g], exp_be[g],
         exp_cmd[g][`FB_CMD_WE_BIT]));
   end

   initial begin
      forever begin
         @(posedge CLK);
         cycle_cnt++;
         if (cycle_cnt > 200 * n_trans + 1000) begin
            report_failure("watchdog timeout, a bus or TCDM handshake never completed");
         end
      end
   end

   initial begin
      int                     r;
      fpga_bridge_pkg::word_t w;
      fpga_bridge_pkg::word_t cmd;
      fpga_bridge_pkg::word_t wd;
      fpga_bridge_pkg::be_t   be;
      seed      = 71;
      n_trans   = 0;
      cycle_cnt = 0;
      rst       = 1'b1;
      lint_req  = 1'b0;
      lint_wen  = 1'b1;
      lint_addr = '0;
      lint_wdata = '0;
      lint_be   = '0;
      chk_rd    = 1'b0;
      exp_rd    = '0;
      chk_addr  = '0;
      exp_out   = '0;
      exp_oe    = '0;
      nxt_out   = '0;
      nxt_oe    = '0;
      launched  = '0;
      resp_en   = '0;
      for (int i = 0; i < `FB_NUM_PORTS; i++) begin
         exp_cmd[i]    = '0;
         exp_be[i]     = '0;
         exp_wd[i]     = '0;
         resp_delay[i] = 0;
         resp_word[i]  = '0;
      end
      r = $random(seed);
      fpgaio_in[31:0] = r;
      r = $random(seed);
      fpgaio_in[63:32] = r;
      r = $random(seed);
      fpgaio_in[79:64] = r[15:0];

      repeat (4) @(posedge CLK);
      #5;
      rst = 1'b0;
      next_cycle();

      bus_read(`FB_ID_ADDR, `FB_ID_VALUE);
      bus_read(20'h00f00, '0);  // unmapped

      for (int k = 0; k < 3; k++) begin
         w = $random(seed);
         if (k == 2) nxt_out[79:64] = w[15:0];
         else nxt_out[k*32 +: 32] = w;
         bus_access(1'b1, reg_addr(`FB_GPIO_OUT_BASE, k), w, 4'hf);
         w = $random(seed);
         if (k == 2) nxt_oe[79:64] = w[15:0];
         else nxt_oe[k*32 +: 32] = w;
         bus_access(1'b1, reg_addr(`FB_GPIO_OE_BASE, k), w, 4'hf);
      end
      for (int k = 0; k < 3; k++) begin
         bus_read(reg_addr(`FB_GPIO_OUT_BASE, k), expected_slice(exp_out, k));
         bus_read(reg_addr(`FB_GPIO_OE_BASE, k), expected_slice(exp_oe, k));
         bus_read(reg_addr(`FB_GPIO_IN_BASE, k), expected_slice(fpgaio_in, k));
      end

      for (int i = 0; i < `FB_NUM_PORTS; i++) begin
         cmd = $random(seed);
         wd  = $random(seed);
         r   = $random(seed);
         be  = r[3:0];
         bus_access(1'b1, reg_addr(`FB_CMD_BASE, i), cmd, be);
         exp_cmd[i] = cmd;
         exp_be[i]  = be;
         bus_access(1'b1, reg_addr(`FB_WDATA_BASE, i), wd, 4'hf);
         exp_wd[i]   = wd;
         launched[i] = 1'b1;
         bus_access(1'b1, reg_addr(`FB_REQ_BASE, i), 32'h1, 4'hf);
         bus_read(reg_addr(`FB_REQ_BASE, i), 32'h1);
         bus_access(1'b1, reg_addr(`FB_CMD_BASE, i), ~cmd, ~be);  // must be ignored
         bus_read(reg_addr(`FB_CMD_BASE, i), cmd);
         r = $random(seed);
         resp_delay[i] = $unsigned(r) % 6;
         resp_word[i]  = $random(seed);
         resp_en[i]    = 1'b1;
         do @(posedge CLK); while (!tcdm_valid[i]);
         #5;
         launched[i] = 1'b0;
         bus_read(reg_addr(`FB_REQ_BASE, i), '0);
         bus_read(reg_addr(`FB_WDATA_BASE, i), resp_word[i]);
         bus_read(reg_addr(`FB_CMD_BASE, i), cmd);
      end

      repeat (4) next_cycle();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/fpga_bridge_top.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

module fpga_bridge_top (
   input  wire                              CLK,
   input  wire                              rst,
   // lint register bus
   input  wire                              lint_req,
   input  wire                              lint_wen,
   input  wire fpga_bridge_pkg::bus_addr_t  lint_addr,
   input  wire fpga_bridge_pkg::word_t      lint_wdata,
   input  wire fpga_bridge_pkg::be_t        lint_be,
   output wire                              lint_gnt,
   output wire                              lint_valid,
   output wire fpga_bridge_pkg::word_t      lint_rdata,
   // fpga io
   output wire fpga_bridge_pkg::gpio_t      fpgaio_out,
   output wire fpga_bridge_pkg::gpio_t      fpgaio_oe,
   input  wire fpga_bridge_pkg::gpio_t      fpgaio_in,
   // tcdm masters, one entry per port
   output wire fpga_bridge_pkg::tcdm_addr_t tcdm_addr [`FB_NUM_PORTS],
   output wire [`FB_NUM_PORTS-1:0]          tcdm_we,
   output wire fpga_bridge_pkg::be_t        tcdm_be [`FB_NUM_PORTS],
   output wire fpga_bridge_pkg::word_t      tcdm_wdata [`FB_NUM_PORTS],
   output wire [`FB_NUM_PORTS-1:0]          tcdm_req,
   input  wire [`FB_NUM_PORTS-1:0]          tcdm_gnt,
   input  wire [`FB_NUM_PORTS-1:0]          tcdm_valid,
   input  wire fpga_bridge_pkg::word_t      tcdm_rdata [`FB_NUM_PORTS]
);

   reg_wr_if wr_bus ();

   wire fpga_bridge_pkg::bus_addr_t rd_addr;
   wire fpga_bridge_pkg::word_t     rd_word;
   wire fpga_bridge_pkg::word_t     cmd_word [`FB_NUM_PORTS];
   wire fpga_bridge_pkg::word_t     result [`FB_NUM_PORTS];
   wire [`FB_NUM_PORTS-1:0]         pending;

   lint_slave u_lint_slave (
      .CLK     (CLK),
      .rst     (rst),
      .req     (lint_req),
      .wen     (lint_wen),
      .addr    (lint_addr),
      .wdata   (lint_wdata),
      .be      (lint_be),
      .rd_word (rd_word),
      .gnt     (lint_gnt),
      .valid   (lint_valid),
      .rdata   (lint_rdata),
      .rd_addr (rd_addr),
      .wr      (wr_bus.master)
   );

   gpio_regs u_gpio_regs (
      .CLK      (CLK),
      .rst      (rst),
      .gpio_out (fpgaio_out),
      .gpio_oe  (fpgaio_oe),
      .wr       (wr_bus.target)
   );

   for (genvar i = 0; i < `FB_NUM_PORTS; i++) begin : g_port
      tcdm_port u_port (
         .CLK        (CLK),
         .rst        (rst),
         .port_id    (fpga_bridge_pkg::port_idx_t'(i)),  // selects its own addresses
         .tcdm_gnt   (tcdm_gnt[i]),
         .tcdm_valid (tcdm_valid[i]),
         .tcdm_rdata (tcdm_rdata[i]),
         .tcdm_addr  (tcdm_addr[i]),
         .tcdm_we    (tcdm_we[i]),
         .tcdm_be    (tcdm_be[i]),
         .tcdm_wdata (tcdm_wdata[i]),
         .tcdm_req   (tcdm_req[i]),
         .cmd_word   (cmd_word[i]),
         .result     (result[i]),
         .pending    (pending[i]),
         .wr         (wr_bus.target)
      );
   end

   read_mux u_read_mux (
      .rd_addr  (rd_addr),
      .cmd_word (cmd_word),
      .result   (result),
      .pending  (pending),
      .gpio_out (fpgaio_out),
      .gpio_oe  (fpgaio_oe),
      .gpio_in  (fpgaio_in),
      .rd_word  (rd_word)
   );

endmodule

`default_nettype wire

// ==== hdl/read_mux.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

module read_mux (
   input  wire fpga_bridge_pkg::bus_addr_t rd_addr,
   input  wire fpga_bridge_pkg::word_t     cmd_word [`FB_NUM_PORTS],
   input  wire fpga_bridge_pkg::word_t     result [`FB_NUM_PORTS],
   input  wire [`FB_NUM_PORTS-1:0]         pending,
   input  wire fpga_bridge_pkg::gpio_t     gpio_out,
   input  wire fpga_bridge_pkg::gpio_t     gpio_oe,
   input  wire fpga_bridge_pkg::gpio_t     gpio_in,
   output fpga_bridge_pkg::word_t          rd_word
);

   // slot 2 is the 16 bit top slice, zero extended
   function automatic fpga_bridge_pkg::word_t get_word(
      input fpga_bridge_pkg::gpio_t v,
      input logic [1:0]             slot
   );
      fpga_bridge_pkg::word_t w;
      case (slot)
         2'd0:    w = v[31:0];
         2'd1:    w = v[63:32];
         2'd2:    w = fpga_bridge_pkg::word_t'(v[`FB_GPIO_W-1:64]);
         default: w = '0;
      endcase
      return w;
   endfunction

   always_comb begin
      rd_word = '0;  // unmapped
      case (rd_addr)
         `FB_GPIO_OUT_BASE:           rd_word = get_word(gpio_out, 2'd0);
         `FB_GPIO_OUT_BASE + 20'h4:   rd_word = get_word(gpio_out, 2'd1);
         `FB_GPIO_OUT_BASE + 20'h8:   rd_word = get_word(gpio_out, 2'd2);
         `FB_GPIO_OE_BASE:            rd_word = get_word(gpio_oe, 2'd0);
         `FB_GPIO_OE_BASE + 20'h4:    rd_word = get_word(gpio_oe, 2'd1);
         `FB_GPIO_OE_BASE + 20'h8:    rd_word = get_word(gpio_oe, 2'd2);
         `FB_GPIO_IN_BASE:            rd_word = get_word(gpio_in, 2'd0);
         `FB_GPIO_IN_BASE + 20'h4:    rd_word = get_word(gpio_in, 2'd1);
         `FB_GPIO_IN_BASE + 20'h8:    rd_word = get_word(gpio_in, 2'd2);
         `FB_ID_ADDR:                 rd_word = `FB_ID_VALUE;
         default: begin
            // per port windows
            for (int i = 0; i < `FB_NUM_PORTS; i++) begin
               if (rd_addr == `FB_CMD_BASE + fpga_bridge_pkg::bus_addr_t'(4 * i)) begin
                  rd_word = cmd_word[i];
               end
               if (rd_addr == `FB_WDATA_BASE + fpga_bridge_pkg::bus_addr_t'(4 * i)) begin
                  rd_word = result[i];
               end
               if (rd_addr == `FB_REQ_BASE + fpga_bridge_pkg::bus_addr_t'(4 * i)) begin
                  rd_word = fpga_bridge_pkg::word_t'(pending[i]);
               end
            end
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/gpio_regs.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

module gpio_regs (
   input  wire                    CLK,
   input  wire                    rst,
   output fpga_bridge_pkg::gpio_t gpio_out,
   output fpga_bridge_pkg::gpio_t gpio_oe,
   reg_wr_if.target               wr
);

   fpga_bridge_pkg::bus_addr_t out_off;
   fpga_bridge_pkg::bus_addr_t oe_off;
   logic                       out_hit;
   logic                       oe_hit;

   // three word slots per 80 bit register, top one only 16 bits wide
   function automatic fpga_bridge_pkg::gpio_t put_word(
      input fpga_bridge_pkg::gpio_t cur,
      input logic [1:0]             slot,
      input fpga_bridge_pkg::word_t d
   );
      fpga_bridge_pkg::gpio_t nxt;
      nxt = cur;
      case (slot)
         2'd0:    nxt[31:0]              = d;
         2'd1:    nxt[63:32]             = d;
         2'd2:    nxt[`FB_GPIO_W-1:64]   = d[`FB_GPIO_W-65:0];
         default: nxt                    = cur;
      endcase
      return nxt;
   endfunction

   assign out_off = wr.addr - `FB_GPIO_OUT_BASE;
   assign oe_off  = wr.addr - `FB_GPIO_OE_BASE;

   // word aligned, slots 0 to 2
   assign out_hit = wr.wr_en && (out_off[`FB_ADDR_W-1:4] == '0)
                    && (out_off[1:0] == 2'b00) && (out_off[3:2] != 2'b11);
   assign oe_hit  = wr.wr_en && (oe_off[`FB_ADDR_W-1:4] == '0)
                    && (oe_off[1:0] == 2'b00) && (oe_off[3:2] != 2'b11);

   always_ff @(posedge CLK) begin
      if (rst) begin
         gpio_out <= '0;
         gpio_oe  <= '0;
      end else begin
         if (out_hit) begin
            gpio_out <= put_word(gpio_out, out_off[3:2], wr.wdata);
         end
         if (oe_hit) begin
            gpio_oe <= put_word(gpio_oe, oe_off[3:2], wr.wdata);
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/tcdm_port.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

module tcdm_port (
   input  wire                             CLK,
   input  wire                             rst,
   input  wire fpga_bridge_pkg::port_idx_t port_id,
   input  wire                             tcdm_gnt,
   input  wire                             tcdm_valid,
   input  wire fpga_bridge_pkg::word_t     tcdm_rdata,
   output fpga_bridge_pkg::tcdm_addr_t     tcdm_addr,
   output logic                            tcdm_we,
   output fpga_bridge_pkg::be_t            tcdm_be,
   output fpga_bridge_pkg::word_t          tcdm_wdata,
   output logic                            tcdm_req,
   output fpga_bridge_pkg::word_t          cmd_word,
   output fpga_bridge_pkg::word_t          result,
   output logic                            pending,
   reg_wr_if.target                        wr
);

   fpga_bridge_pkg::bus_addr_t port_off;
   fpga_bridge_pkg::word_t     cmd_q;
   logic                       cmd_hit;
   logic                       data_hit;
   logic                       req_hit;

   assign port_off = {{(`FB_ADDR_W - 4){1'b0}}, port_id, 2'b00};  // 4 * port_id

   assign cmd_hit  = wr.wr_en && (wr.addr == `FB_CMD_BASE + port_off);
   assign data_hit = wr.wr_en && (wr.addr == `FB_WDATA_BASE + port_off);
   assign req_hit  = wr.wr_en && (wr.addr == `FB_REQ_BASE + port_off);

   always_ff @(posedge CLK) begin
      if (rst) begin
         cmd_q      <= '0;
         tcdm_be    <= '0;
         tcdm_wdata <= '0;
         tcdm_req   <= 1'b0;
         result     <= '0;
      end else begin
         // config frozen while a request is outstanding
         if (cmd_hit && !tcdm_req) begin
            cmd_q   <= wr.wdata;
            tcdm_be <= wr.be;
         end
         if (data_hit && !tcdm_req) begin
            tcdm_wdata <= wr.wdata;
         end
         if (tcdm_req) begin
            if (tcdm_gnt) begin
               tcdm_req <= 1'b0;
            end
         end else if (req_hit) begin
            tcdm_req <= 1'b1;
         end
         if (tcdm_valid) begin
            result <= tcdm_rdata;
         end
      end
   end

   assign tcdm_addr = cmd_q[`FB_TCDM_ADDR_W-1:0];
   assign tcdm_we   = cmd_q[`FB_CMD_WE_BIT];
   assign cmd_word  = cmd_q;
   assign pending   = tcdm_req;

   // request fields must hold until the slave grants
   a_req_hold: assert property (
      @(posedge CLK) disable iff (rst)
      tcdm_req && !tcdm_gnt |=> tcdm_req && $stable(tcdm_addr) && $stable(tcdm_we)
         && $stable(tcdm_be) && $stable(tcdm_wdata)
   ) else $error("tcdm port %0d changed request before grant", port_id);

endmodule

`default_nettype wire

// ==== hdl/lint_slave.sv ====
`default_nettype none

module lint_slave (
   input  wire                             CLK,
   input  wire                             rst,
   input  wire                             req,
   input  wire                             wen,      // low for write
   input  wire fpga_bridge_pkg::bus_addr_t addr,
   input  wire fpga_bridge_pkg::word_t     wdata,
   input  wire fpga_bridge_pkg::be_t       be,
   input  wire fpga_bridge_pkg::word_t     rd_word,
   output logic                            gnt,
   output logic                            valid,
   output fpga_bridge_pkg::word_t          rdata,
   output fpga_bridge_pkg::bus_addr_t      rd_addr,
   reg_wr_if.master                        wr
);

   fpga_bridge_pkg::lint_state_t state;

   // addr, wdata and be held by the host until gnt
   always_ff @(posedge CLK) begin
      if (rst) begin
         state <= fpga_bridge_pkg::IDLE;
         gnt   <= 1'b0;
         valid <= 1'b0;
         rdata <= '0;
      end else begin
         gnt   <= 1'b0;
         valid <= 1'b0;
         case (state)
            fpga_bridge_pkg::IDLE: begin
               if (req) begin
                  state <= fpga_bridge_pkg::ACCESS;
               end
            end
            fpga_bridge_pkg::ACCESS: begin
               gnt   <= 1'b1;
               state <= fpga_bridge_pkg::RESPOND;
               if (wen) begin
                  rdata <= rd_word;  // read capture
               end
            end
            fpga_bridge_pkg::RESPOND: begin
               valid <= 1'b1;
               state <= fpga_bridge_pkg::IDLE;
            end
            default: begin
               state <= fpga_bridge_pkg::IDLE;
            end
         endcase
      end
   end

   // write strobe lands on the same edge as gnt
   assign wr.wr_en = (state == fpga_bridge_pkg::ACCESS) && !wen;
   assign wr.addr  = addr;
   assign wr.wdata = wdata;
   assign wr.be    = be;

   assign rd_addr = addr;

   a_gnt_valid_excl: assert property (
      @(posedge CLK) disable iff (rst)
      !(gnt && valid)
   ) else $error("lint gnt and valid high together");

   a_valid_after_gnt: assert property (
      @(posedge CLK) disable iff (rst)
      gnt |=> valid
   ) else $error("lint valid missing after gnt");

   a_valid_needs_gnt: assert property (
      @(posedge CLK) disable iff (rst)
      valid |-> $past(gnt)
   ) else $error("lint valid without preceding gnt");

endmodule

`default_nettype wire

// ==== hdl/reg_wr_if.sv ====
`default_nettype none

// one decoded register write, fanned out to every register block
interface reg_wr_if;

   logic                       wr_en;  // single cycle
   fpga_bridge_pkg::bus_addr_t addr;
   fpga_bridge_pkg::word_t     wdata;
   fpga_bridge_pkg::be_t       be;

   modport master (
      output wr_en,
      output addr,
      output wdata,
      output be
   );

   modport target (
      input wr_en,
      input addr,
      input wdata,
      input be
   );

endinterface

`default_nettype wire

// ==== hdl/fpga_bridge_pkg.sv ====
`default_nettype none

`include "fpga_bridge_settings.svh"

package fpga_bridge_pkg;

   // lint bus side
   typedef logic [`FB_ADDR_W-1:0]      bus_addr_t;
   typedef logic [`FB_DATA_W-1:0]      word_t;
   typedef logic [`FB_BE_W-1:0]        be_t;

   // tcdm master side
   typedef logic [`FB_TCDM_ADDR_W-1:0] tcdm_addr_t;
   typedef logic [$clog2(`FB_NUM_PORTS)-1:0] port_idx_t;

   // fpga io lines
   typedef logic [`FB_GPIO_W-1:0]      gpio_t;

   // lint access sequence
   typedef enum logic [1:0] {
      IDLE,
      ACCESS,   // write strobe, read capture
      RESPOND   // valid back to the host
   } lint_state_t;

endpackage

`default_nettype wire

// ==== hdl/fpga_bridge_settings.svh ====
`ifndef FPGA_BRIDGE_SETTINGS_SVH
`define FPGA_BRIDGE_SETTINGS_SVH

// bus and datapath widths
`define FB_ADDR_W          20
`define FB_DATA_W          32
`define FB_TCDM_ADDR_W     20
`define FB_BE_W            4
`define FB_GPIO_W          80
`define FB_NUM_PORTS       4

// register map, byte addresses on the lint bus
`define FB_CMD_BASE        20'h00000  // one word per port
`define FB_WDATA_BASE      20'h00080  // write data, result on read
`define FB_REQ_BASE        20'h00090  // request strobe, pending on read
`define FB_GPIO_OUT_BASE   20'h00040
`define FB_GPIO_OE_BASE    20'h00050
`define FB_GPIO_IN_BASE    20'h00060
`define FB_ID_ADDR         20'h01000

`define FB_ID_VALUE        32'hca11ef3a

// command word layout
`define FB_CMD_WE_BIT      31

`endif
